//--- sim.f
fetch_pkg.sv
branch_history_table.sv
branch_target_buffer.sv
inst_rom.sv
fetch_ctrl.sv
if_stage.sv
if_stage_assertions.sv
tb_if_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_if_stage
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage import fetch_pkg::*; ();

    localparam int AW          = $clog2(DEF_IMEM_WORDS);
    localparam int N_CYCLES    = 6000;
    localparam int STALL_LIMIT = 100;

    logic          clk;
    logic          rst_n;
    logic          imem_we;
    logic [AW-1:0] imem_addr;
    xlen_t         imem_wdata;
    resolve_t      resolve_in;
    logic          credit_return;
    logic          fetch_valid;
    fetch_pkt_t    fetch_pkt;

    logic [31:0] seed;
    xlen_t       prog [DEF_IMEM_WORDS];
    logic [1:0]  m_bht [DEF_BHT_ENTRIES];
    logic        m_btb_valid [DEF_BTB_ENTRIES];
    xlen_t       m_btb_pc [DEF_BTB_ENTRIES];
    xlen_t       m_btb_target [DEF_BTB_ENTRIES];
    xlen_t       m_pc;
    int          m_credits;
    logic        m_run;
    logic        exp_valid;
    logic        exp_pred;
    xlen_t       exp_inst;
    xlen_t       exp_target;
    xlen_t       fetched [$];
    int          errors    = 0;
    int          checks    = 0;
    int          packets   = 0;
    int          predicted = 0;
    int          redirects = 0;
    int          idle      = 0;

    if_stage #(
        .BHT_ENTRIES   (DEF_BHT_ENTRIES),
        .BTB_ENTRIES   (DEF_BTB_ENTRIES),
        .IMEM_WORDS    (DEF_IMEM_WORDS),
        .FETCH_CREDITS (DEF_FETCH_CREDITS),
        .RESET_PC      (DEF_RESET_PC)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .resolve_in    (resolve_in),
        .fetch_valid   (fetch_valid),
        .fetch_pkt     (fetch_pkt),
        .credit_return (credit_return)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 15);
    endfunction

    function automatic int bht_index(input xlen_t pc);
        return int'((pc >> 2) % DEF_BHT_ENTRIES);
    endfunction

    function automatic int btb_index(input xlen_t pc);
        return int'((pc >> 2) % DEF_BTB_ENTRIES);
    endfunction

    task automatic compare(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Expected outputs for the current cycle, from model state before the edge
    task automatic predict_outputs();
        int   ti;
        logic hit;
        ti         = btb_index(m_pc);
        // Tag plus index is the whole word address
        hit        = m_btb_valid[ti] && ((m_btb_pc[ti] >> 2) == (m_pc >> 2));
        exp_inst   = prog[(m_pc >> 2) % DEF_IMEM_WORDS];
        exp_target = m_btb_target[ti];
        exp_valid  = m_run && (m_credits > 0) && !(resolve_in.valid && resolve_in.mispredict);
        exp_pred   = (exp_inst[6:0] == OPC_BRANCH) && hit && m_bht[bht_index(m_pc)][1];
    endtask

    task automatic update_model();
        int bi;
        int ti;
        if (resolve_in.valid && resolve_in.mispredict) begin
            m_pc = resolve_in.taken ? resolve_in.target : resolve_in.pc + 32'd4;
            redirects++;
        end else if (exp_valid) begin
            packets++;
            fetched.push_back(m_pc);
            if (fetched.size() > 8) begin
                fetched.delete(0);
            end
            if (exp_pred) begin
                predicted++;
            end
            m_pc = exp_pred ? exp_target : m_pc + 32'd4;
        end
        m_credits = m_credits + (credit_return ? 1 : 0) - (exp_valid ? 1 : 0);
        // Training sees the resolve of this cycle
        if (resolve_in.valid) begin
            bi = bht_index(resolve_in.pc);
            ti = btb_index(resolve_in.pc);
            if (resolve_in.taken && m_bht[bi] != 2'b11) begin
                m_bht[bi] = m_bht[bi] + 2'd1;
            end else if (!resolve_in.taken && m_bht[bi] != 2'b00) begin
                m_bht[bi] = m_bht[bi] - 2'd1;
            end
            if (resolve_in.taken) begin
                m_btb_valid[ti]  = 1'b1;
                m_btb_pc[ti]     = resolve_in.pc;
                m_btb_target[ti] = resolve_in.target;
            end
        end
        m_run = 1'b1;
    endtask

    task automatic drive_stimulus(input int cycle);
        logic [31:0] r;
        resolve_t    res;
        r   = rand32();
        res = '0;
        // Decode sits on its credits early in every 200-cycle window
        credit_return <= (m_credits < DEF_FETCH_CREDITS) && (cycle % 200 >= 30)
                         && (r[31:30] != 2'b00);
        if (fetched.size() > 0 && r[29:28] == 2'b00) begin
            res.valid      = 1'b1;
            res.pc         = fetched[0];
            res.taken      = (r[27:26] != 2'b00);
            res.target     = {21'd0, r[10:2], 2'b00};
            res.mispredict = (r[25:24] == 2'b00);
            fetched.delete(0);
        end
        resolve_in <= res;
    endtask

    initial begin
        xlen_t word;
        seed          = 32'h949dde3e;
        clk           = 1'b0;
        rst_n         = 1'b0;
        imem_we       = 1'b0;
        imem_addr     = '0;
        imem_wdata    = '0;
        resolve_in    = '0;
        credit_return = 1'b0;
        for (int i = 0; i < DEF_IMEM_WORDS; i++) begin
            word = rand32();
            if (rand32() % 4 == 0) begin
                word[6:0] = OPC_BRANCH;
            end
            prog[i] = word;
        end
        // Program load while the stage is in reset
        for (int i = 0; i < DEF_IMEM_WORDS; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= AW'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        m_pc      = DEF_RESET_PC;
        m_credits = DEF_FETCH_CREDITS;
        m_run     = 1'b0;
        for (int i = 0; i < DEF_BHT_ENTRIES; i++) begin
            m_bht[i] = 2'b01;
        end
        for (int i = 0; i < DEF_BTB_ENTRIES; i++) begin
            m_btb_valid[i]  = 1'b0;
            m_btb_pc[i]     = '0;
            m_btb_target[i] = '0;
        end
        for (int cycle = 0; cycle < N_CYCLES; cycle++) begin
            @(negedge clk);
            predict_outputs();
            compare("fetch_valid", 32'(fetch_valid), 32'(exp_valid));
            if (exp_valid && fetch_valid) begin
                compare("fetch_pkt.pc", fetch_pkt.pc, m_pc);
                compare("fetch_pkt.inst", fetch_pkt.inst, exp_inst);
                compare("fetch_pkt.pred_taken", 32'(fetch_pkt.pred_taken), 32'(exp_pred));
            end
            idle = fetch_valid ? 0 : idle + 1;
            if (idle > STALL_LIMIT) begin
                errors++;
                $display("Timeout: no packet from the DUT for %0d cycles", STALL_LIMIT);
                break;
            end
            @(posedge clk);
            update_model();
            drive_stimulus(cycle);
        end
        if (predicted == 0) begin
            errors++;
            $display("No fetched branch was ever predicted taken");
        end
        $display("Checks %0d, packets %0d, predicted %0d, redirects %0d, errors %0d",
                 checks, packets, predicted, redirects, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- if_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage_assertions import fetch_pkg::*; #(
    parameter int CREDITS = DEF_FETCH_CREDITS
) (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       fetch_valid,
    input wire fetch_pkt_t fetch_pkt,
    input wire resolve_t   resolve_in,
    input wire logic       credit_return
);

    logic  redirect;
    xlen_t redirect_pc;
    int    credits;

    assign redirect    = resolve_in.valid && resolve_in.mispredict;
    assign redirect_pc = resolve_in.taken ? resolve_in.target : resolve_in.pc + 32'd4;

    // Credits as seen from the decode side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDITS;
        end else begin
            credits <= credits + int'(credit_return) - int'(fetch_valid);
        end
    end

    no_packet_without_credit: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_valid |-> (credits > 0)
    ) else $error("fetch_valid high with zero credits");

    // Redirect cycles carry no packet, then pc follows the resolve
    redirect_to_resolved_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |=> !$past(fetch_valid) && (fetch_pkt.pc == $past(redirect_pc))
    ) else $error("redirect sent a packet or did not load the resolved pc");

    credits_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) credits <= CREDITS
    ) else $error("credit count above its limit");

endmodule

bind if_stage if_stage_assertions #(
    .CREDITS (FETCH_CREDITS)
) u_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid   (fetch_valid),
    .fetch_pkt     (fetch_pkt),
    .resolve_in    (resolve_in),
    .credit_return (credit_return)
);

`default_nettype wire

//--- if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage import fetch_pkg::*; #(
    parameter int    BHT_ENTRIES   = DEF_BHT_ENTRIES,
    parameter int    BTB_ENTRIES   = DEF_BTB_ENTRIES,
    parameter int    IMEM_WORDS    = DEF_IMEM_WORDS,
    parameter int    FETCH_CREDITS = DEF_FETCH_CREDITS,
    parameter xlen_t RESET_PC      = DEF_RESET_PC
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          imem_we,
    input  wire logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  wire xlen_t                         imem_wdata,
    input  wire resolve_t                      resolve_in,
    output logic                               fetch_valid,
    output fetch_pkt_t                         fetch_pkt,
    input  wire logic                          credit_return
);

    xlen_t pc;
    xlen_t inst;
    logic  counter_taken;
    logic  hit;
    xlen_t target;

    fetch_ctrl #(
        .CREDITS  (FETCH_CREDITS),
        .RESET_PC (RESET_PC)
    ) u_fetch_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst          (inst),
        .counter_taken (counter_taken),
        .hit           (hit),
        .target        (target),
        .resolve_in    (resolve_in),
        .credit_return (credit_return),
        .pc            (pc),
        .fetch_valid   (fetch_valid),
        .fetch_pkt     (fetch_pkt)
    );

    branch_history_table #(
        .ENTRIES (BHT_ENTRIES)
    ) u_bht (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc            (pc),
        .resolve_in    (resolve_in),
        .counter_taken (counter_taken)
    );

    branch_target_buffer #(
        .ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .resolve_in (resolve_in),
        .hit        (hit),
        .target     (target)
    );

    inst_rom #(
        .WORDS (IMEM_WORDS)
    ) u_imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .pc    (pc),
        .inst  (inst)
    );

endmodule

`default_nettype wire

//--- fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import fetch_pkg::*; #(
    parameter int    CREDITS  = DEF_FETCH_CREDITS,
    parameter xlen_t RESET_PC = DEF_RESET_PC
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire xlen_t    inst,
    input  wire logic     counter_taken,
    input  wire logic     hit,
    input  wire xlen_t    target,
    input  wire resolve_t resolve_in,
    input  wire logic     credit_return,
    output xlen_t         pc,
    output logic          fetch_valid,
    output fetch_pkt_t    fetch_pkt
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credits;
    logic          run;
    logic          redirect;
    logic          is_branch;
    logic          pred;
    xlen_t         next_pc;

    assign redirect  = resolve_in.valid && resolve_in.mispredict;
    assign is_branch = (inst[6:0] == OPC_BRANCH);
    assign pred      = is_branch && hit && counter_taken;

    // First cycle out of reset never fetches
    assign fetch_valid = run && (credits != '0) && !redirect;

    always_comb begin
        fetch_pkt.pc         = pc;
        fetch_pkt.inst       = inst;
        fetch_pkt.pred_taken = pred;
    end

    // Redirect wins over fetch, stall holds pc
    always_comb begin
        if (redirect) begin
            if (resolve_in.taken) begin
                next_pc = resolve_in.target;
            end else begin
                next_pc = resolve_in.pc + 32'd4;
            end
        end else if (fetch_valid) begin
            if (pred) begin
                next_pc = target;
            end else begin
                next_pc = pc + 32'd4;
            end
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            credits <= CW'(CREDITS);
            run     <= 1'b0;
        end else begin
            pc  <= next_pc;
            run <= 1'b1;
            // Spend and return may coincide
            case ({credit_return, fetch_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom import fetch_pkg::*; #(
    parameter int WORDS = DEF_IMEM_WORDS
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(WORDS)-1:0] waddr,
    input  wire xlen_t                    wdata,
    input  wire xlen_t                    pc,
    output xlen_t                         inst
);

    localparam int AW = $clog2(WORDS);

    xlen_t          mem [WORDS];
    logic [AW-1:0]  rd_addr;

    // Byte PC to word index
    assign rd_addr = pc[AW+1:2];
    assign inst    = mem[rd_addr];

    // Loader port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer import fetch_pkg::*; #(
    parameter int ENTRIES = DEF_BTB_ENTRIES
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire xlen_t    pc,
    input  wire resolve_t resolve_in,
    output logic          hit,
    output xlen_t         target
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 32 - IDX_W - 2;

    logic             valid_q  [ENTRIES];
    logic [TAG_W-1:0] tag_q    [ENTRIES];
    xlen_t            target_q [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[31:IDX_W+2];
    assign wr_idx = resolve_in.pc[IDX_W+1:2];
    assign wr_tag = resolve_in.pc[31:IDX_W+2];

    // Only taken branches allocate
    assign wr_en = resolve_in.valid && resolve_in.taken;

    assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target = target_q[rd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= resolve_in.target;
        end
    end

endmodule

`default_nettype wire

//--- branch_history_table.sv
`timescale 1ns/1ps
`default_nettype none

module branch_history_table import fetch_pkg::*; #(
    parameter int ENTRIES = DEF_BHT_ENTRIES
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire xlen_t    pc,
    input  wire resolve_t resolve_in,
    output logic          counter_taken
);

    localparam int IDX_W = $clog2(ENTRIES);

    logic [1:0]       counters [ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // Word-aligned PC bits select the counter
    assign rd_idx = pc[IDX_W+1:2];
    assign wr_idx = resolve_in.pc[IDX_W+1:2];

    assign counter_taken = counters[rd_idx][1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Weakly not-taken
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (resolve_in.valid) begin
            if (resolve_in.taken) begin
                if (counters[wr_idx] != 2'b11) begin
                    counters[wr_idx] <= counters[wr_idx] + 2'd1;
                end
            end else begin
                if (counters[wr_idx] != 2'b00) begin
                    counters[wr_idx] <= counters[wr_idx] - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] xlen_t;

    // Packet handed to decode
    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
        logic  pred_taken;
    } fetch_pkt_t;

    // Branch outcome from execute
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        logic  taken;
        xlen_t target;
        logic  mispredict;
    } resolve_t;

    // Conditional branch major opcode
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam int    DEF_BHT_ENTRIES   = 64;
    localparam int    DEF_BTB_ENTRIES   = 16;
    localparam int    DEF_IMEM_WORDS    = 256;
    localparam int    DEF_FETCH_CREDITS = 4;
    localparam xlen_t DEF_RESET_PC      = 32'h0000_0000;

endpackage

`default_nettype wire
